/* reg_access_top.f */
common/reg_access_pkg.sv
source/stage_ctrl.sv
source/esp_write_counter.sv
regfile/gpr_file.sv
source/stack_tracker.sv
source/reg_access_top.sv
dv/reg_access_sva.sv
dv/reg_access_tb.sv

/* Makefile */
TOP   = reg_access_tb
FLIST = reg_access_top.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module reg_access_top -f $(FLIST)

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "TEST PASS" sim.log; then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* dv/reg_access_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register access stage testbench
// Reference model, scoreboard queue and checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module reg_access_tb;
    import reg_access_pkg::*;

    typedef logic [7:0][31:0] regs_t;

    localparam int WAIT_LIMIT = 100;

    logic           clk = 1'b0;
    logic           arst_n;
    logic           flush;
    logic           flag_df;
    logic           d_valid;
    logic           d_ready;
    decode_bundle_t dec;
    logic           r_valid;
    logic           r_ready;
    issue_bundle_t  issue;
    gpr_wb_t        wb_reg;
    stack_commit_t  wb_stack;

    // Model state and scoreboard
    regs_t          model_regs;
    data_t          model_spec;
    issue_bundle_t  exp_q[$];
    logic           bp_on;
    int             errors;
    int             checks;
    int             tests;
    int             failed_tests;
    int             test_start_errors;
    string          test_name;

    reg_access_top #(.DATA_W(32), .CNT_W(3)) uut (.*);

    bind reg_access_top reg_access_sva u_sva (.*);

    always #10 clk = ~clk;

    // Two's complement ESP movement of one stack op
    function automatic data_t esp_step(input stack_op_t op, input op_size_e size);
        if (op[1]) begin
            return (size == SIZE_DWORD) ? 32'd4 : 32'd2;
        end
        if (op[0]) begin
            return (size == SIZE_DWORD) ? -32'd4 : (size == SIZE_WORD) ? -32'd2 : -32'd1;
        end
        return 32'd0;
    endfunction

    function automatic data_t merge(input data_t old_val, input data_t new_val,
                                    input op_size_e size);
        case (size)
            SIZE_BYTE:  return {old_val[31:8], new_val[7:0]};
            SIZE_WORD:  return {old_val[31:16], new_val[15:0]};
            SIZE_DWORD: return new_val;
            default:    return old_val;
        endcase
    endfunction

    // Builds the expected issue bundle and advances the model
    function automatic issue_bundle_t expect_issue(input decode_bundle_t d, input logic df,
                                                   inout regs_t regs, inout data_t spec);
        issue_bundle_t e;
        data_t         mag;
        e.size     = d.size;
        e.op0_kind = d.op0_kind;
        e.op1_kind = d.op1_kind;
        e.stack_op = d.stack_op;
        e.movs     = d.movs;
        e.alu_op   = d.alu_op;
        e.imm      = d.imm;
        e.pc       = d.pc;
        e.op0_reg  = (d.op0_kind == OPK_MODRM_REG) ? d.modrm[2:0] : d.op0_reg;
        e.op1_reg  = (d.op1_kind == OPK_MODRM_REG) ? d.modrm[2:0] : d.op1_reg;
        e.op0_value = regs[e.op0_reg];
        e.op1_value = regs[e.op1_reg];
        // Push points below the old ESP and pop at it
        if (d.stack_op == 2'b01) begin
            spec = spec + esp_step(d.stack_op, d.size);
            e.stack_address = spec;
        end else begin
            e.stack_address = spec;
            spec = spec + esp_step(d.stack_op, d.size);
        end
        if (d.movs) begin
            mag = (d.size == SIZE_DWORD) ? 32'd4 : (d.size == SIZE_WORD) ? 32'd2 :
                  (d.size == SIZE_BYTE) ? 32'd1 : 32'd0;
            regs[6] = df ? regs[6] - mag : regs[6] + mag;
            regs[7] = df ? regs[7] - mag : regs[7] + mag;
        end
        return e;
    endfunction

    function automatic decode_bundle_t rand_dec(input operand_kind_e k0,
                                                input operand_kind_e k1,
                                                input stack_op_t sop, input logic movs);
        decode_bundle_t d;
        d.size     = op_size_e'($urandom_range(3, 0));
        d.op0_kind = k0;
        d.op1_kind = k1;
        d.op0_reg  = reg_num_t'($urandom_range(7, 0));
        d.op1_reg  = reg_num_t'($urandom_range(7, 0));
        d.modrm    = 8'($urandom);
        d.stack_op = sop;
        d.movs     = movs;
        d.alu_op   = 4'($urandom);
        d.imm      = $urandom;
        d.pc       = $urandom;
        // Keep ESP out of op0 so stack ops never wait
        if (sop == 2'b00) begin
            if (d.op0_reg == REG_ESP) begin
                d.op0_reg = 3'd0;
            end
            if (d.modrm[2:0] == REG_ESP) begin
                d.modrm[2:0] = 3'd5;
            end
        end
        return d;
    endfunction

    task automatic report_fail(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_bundle(input issue_bundle_t e);
        logic bad;
        bad = 1'b0;
        if (issue.op0_reg !== e.op0_reg || issue.op1_reg !== e.op1_reg) begin
            report_fail($sformatf("operand numbers %0d/%0d, expected %0d/%0d",
                                  issue.op0_reg, issue.op1_reg, e.op0_reg, e.op1_reg));
            bad = 1'b1;
        end
        if (issue.op0_value !== e.op0_value) begin
            report_fail($sformatf("op0_value %h, expected %h", issue.op0_value, e.op0_value));
            bad = 1'b1;
        end
        if (issue.op1_value !== e.op1_value) begin
            report_fail($sformatf("op1_value %h, expected %h", issue.op1_value, e.op1_value));
            bad = 1'b1;
        end
        if (issue.stack_address !== e.stack_address) begin
            report_fail($sformatf("stack_address %h, expected %h",
                                  issue.stack_address, e.stack_address));
            bad = 1'b1;
        end
        if (!bad && issue !== e) begin
            report_fail($sformatf("bundle for pc %h, expected pc %h", issue.pc, e.pc));
        end
    endtask

    // Compare on every issue transfer at the falling edge
    always @(negedge clk) begin
        if (arst_n && r_valid && r_ready) begin
            checks++;
            if (exp_q.size() == 0) begin
                report_fail("issue transfer with no bundle expected");
            end else begin
                check_bundle(exp_q.pop_front());
            end
        end
    end

    // r_ready is random under back-pressure
    initial begin
        r_ready = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            r_ready = bp_on ? 1'($urandom) : 1'b1;
        end
    end

    task automatic send(input decode_bundle_t d, input logic df);
        int n;
        n = 0;
        dec     = d;
        flag_df = df;
        d_valid = 1'b1;
        @(negedge clk);
        while (!d_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (d_ready) begin
            exp_q.push_back(expect_issue(d, df, model_regs, model_spec));
        end else begin
            $display("Timeout at %0t: decode bundle not accepted in %0d cycles", $time, n);
            errors++;
        end
        @(posedge clk);
        #2;
        d_valid = 1'b0;
    endtask

    task automatic write_reg(input reg_num_t num, input op_size_e wsize, input data_t wdata);
        wb_reg = '{en: 1'b1, number: num, size: wsize, from_stack: 1'b0, data: wdata};
        @(posedge clk);
        model_regs[num] = merge(model_regs[num], wdata, wsize);
        if (num == REG_ESP) begin
            model_spec = wdata;
        end
        #2;
        wb_reg = '0;
    endtask

    task automatic commit_stack(input stack_op_t cop, input op_size_e csize);
        wb_stack = '{en: 1'b1, size: csize, op: cop};
        @(posedge clk);
        model_regs[REG_ESP] = model_regs[REG_ESP] + esp_step(cop, csize);
        #2;
        wb_stack = '0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout at %0t: %0d issue bundles never came out", $time, exp_q.size());
            errors++;
            exp_q.delete();
        end
        @(posedge clk);
        #2;
    endtask

    task automatic flush_stage();
        wait_drain();
        flush = 1'b1;
        @(posedge clk);
        model_spec = model_regs[REG_ESP];
        #2;
        flush = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        wait_drain();
        tests++;
        if (errors == test_start_errors) begin
            $display("Test %s: ok", test_name);
        end else begin
            failed_tests++;
            $display("Test %s: %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    initial begin
        decode_bundle_t d;
        data_t          v;
        void'($urandom(32'he050));
        arst_n       = 1'b0;
        flush        = 1'b0;
        flag_df      = 1'b0;
        d_valid      = 1'b0;
        dec          = '0;
        wb_reg       = '0;
        wb_stack     = '0;
        bp_on        = 1'b0;
        model_regs   = '0;
        model_spec   = '0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        repeat (8) @(posedge clk);

        start_test("reset state");
        if (r_valid !== 1'b0 || d_ready !== 1'b0) begin
            report_fail("r_valid or d_ready high during reset");
        end
        #2;
        arst_n = 1'b1;
        finish_test();

        start_test("sized writeback");
        for (int i = 0; i < 24; i++) begin
            write_reg(reg_num_t'($urandom_range(7, 0)), op_size_e'(i % 3 + 1), $urandom);
        end
        for (int r = 0; r < 4; r++) begin
            d = rand_dec(OPK_REG, OPK_REG, 2'b00, 1'b0);
            d.op0_reg = reg_num_t'(r);
            d.op1_reg = reg_num_t'(7 - r);
            send(d, 1'b0);
        end
        finish_test();

        start_test("operand resolution");
        for (int i = 0; i < 16; i++) begin
            d = rand_dec(i[0] ? OPK_REG : OPK_MODRM_REG, i[1] ? OPK_MODRM_REG : OPK_REG,
                         2'b00, 1'b0);
            send(d, 1'b0);
        end
        finish_test();

        start_test("stack addressing");
        for (int i = 0; i < 16; i++) begin
            d = rand_dec(OPK_MEM, OPK_NONE, stack_op_t'($urandom_range(2, 1)), 1'b0);
            send(d, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            commit_stack(stack_op_t'($urandom_range(2, 1)), op_size_e'($urandom_range(3, 1)));
        end
        flush_stage();
        d = rand_dec(OPK_MEM, OPK_NONE, 2'b01, 1'b0);
        send(d, 1'b0);
        finish_test();

        start_test("string moves");
        for (int i = 0; i < 6; i++) begin
            d = rand_dec(OPK_MEM, OPK_MEM, 2'b00, 1'b1);
            d.size = op_size_e'(i % 3 + 1);
            send(d, i >= 3);
            d = rand_dec(OPK_REG, OPK_REG, 2'b00, 1'b0);
            d.op0_reg = 3'd6;
            d.op1_reg = 3'd7;
            send(d, 1'b0);
        end
        finish_test();

        start_test("back-pressure");
        bp_on = 1'b1;
        for (int i = 0; i < 60; i++) begin
            d = rand_dec(operand_kind_e'($urandom_range(4, 0)),
                         operand_kind_e'($urandom_range(4, 0)),
                         stack_op_t'($urandom), 1'($urandom));
            send(d, 1'($urandom));
        end
        wait_drain();
        bp_on = 1'b0;
        finish_test();

        start_test("ESP hazard");
        d = rand_dec(OPK_REG, OPK_REG, 2'b00, 1'b0);
        d.op0_reg = REG_ESP;
        send(d, 1'b0);
        v = $urandom;
        d = rand_dec(OPK_MEM, OPK_NONE, 2'b01, 1'b0);
        fork
            send(d, 1'b0);
            begin
                repeat (6) begin
                    @(negedge clk);
                    if (d_ready) begin
                        report_fail("d_ready high while an ESP write is pending");
                    end
                end
                @(posedge clk);
                #2;
                write_reg(REG_ESP, SIZE_DWORD, v);
            end
        join
        finish_test();

        $display("Summary: %0d tests, %0d failed, %0d transfers checked, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* dv/reg_access_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register access stage checks
// Handshake, reset and flush properties
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module reg_access_sva
    import reg_access_pkg::*;
(
    input logic          clk,
    input logic          arst_n,
    input logic          flush,
    input logic          d_valid,
    input logic          d_ready,
    input logic          r_valid,
    input logic          r_ready,
    input issue_bundle_t issue
);

    // Held bundle may not change under back-pressure
    a_issue_held: assert property (@(posedge clk) disable iff (!arst_n)
        (r_valid && !r_ready) |=> $stable(issue))
        else $error("issue bundle changed while r_ready was low");

    // First edge out of reset
    a_reset_exit: assert property (@(posedge clk) $rose(arst_n) |-> !r_valid)
        else $error("r_valid high right after reset");

    // Output fills only from an accepted decode transfer
    a_fill_on_accept: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(r_valid) |-> $past(d_valid && d_ready))
        else $error("r_valid rose without a decode transfer");

    a_flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !r_valid)
        else $error("r_valid still high after flush");

endmodule

/* source/reg_access_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register access stage top
// Resolves operands, reads the GPRs and issues
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module reg_access_top
    import reg_access_pkg::*;
#(
    parameter int DATA_W = 32,
    parameter int CNT_W  = 3
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           flush,
    input  logic           flag_df,

    input  logic           d_valid,
    output logic           d_ready,
    input  decode_bundle_t dec,

    output logic           r_valid,
    input  logic           r_ready,
    output issue_bundle_t  issue,

    input  gpr_wb_t        wb_reg,
    input  stack_commit_t  wb_stack
);

    reg_num_t      op0_reg;
    reg_num_t      op1_reg;
    data_t         op0_value;
    data_t         op1_value;
    data_t         arch_esp;
    data_t         stack_address;
    logic          accept;
    logic          is_stack_op;
    logic          esp_dest;
    logic          stack_stall;
    logic          string_step;
    issue_bundle_t next_issue;

    // ModRM reg field replaces the decode register number
    assign op0_reg = (dec.op0_kind == OPK_MODRM_REG) ? dec.modrm[2:0] : dec.op0_reg;
    assign op1_reg = (dec.op1_kind == OPK_MODRM_REG) ? dec.modrm[2:0] : dec.op1_reg;

    assign is_stack_op = |dec.stack_op;

    // Non-stack instruction that will write ESP later
    assign esp_dest = ((dec.op0_kind == OPK_REG) || (dec.op0_kind == OPK_MODRM_REG))
                      && (op0_reg == REG_ESP) && !is_stack_op;

    assign string_step = accept && dec.movs;

    always_comb begin
        next_issue.size          = dec.size;
        next_issue.op0_kind      = dec.op0_kind;
        next_issue.op1_kind      = dec.op1_kind;
        next_issue.op0_reg       = op0_reg;
        next_issue.op1_reg       = op1_reg;
        next_issue.stack_op      = dec.stack_op;
        next_issue.movs          = dec.movs;
        next_issue.alu_op        = dec.alu_op;
        next_issue.imm           = dec.imm;
        next_issue.pc            = dec.pc;
        next_issue.op0_value     = op0_value;
        next_issue.op1_value     = op1_value;
        next_issue.stack_address = stack_address;
    end

    stage_ctrl u_stage_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .d_valid     (d_valid),
        .d_ready     (d_ready),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .is_stack_op (is_stack_op),
        .stack_stall (stack_stall),
        .next_issue  (next_issue),
        .issue       (issue),
        .accept      (accept)
    );

    esp_write_counter #(.CNT_W(CNT_W)) u_esp_write_counter (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .accept      (accept),
        .esp_dest    (esp_dest),
        .wb_reg      (wb_reg),
        .stack_stall (stack_stall)
    );

    gpr_file #(.DATA_W(DATA_W)) u_gpr_file (
        .clk         (clk),
        .arst_n      (arst_n),
        .wb_reg      (wb_reg),
        .wb_stack    (wb_stack),
        .string_step (string_step),
        .flag_df     (flag_df),
        .step_size   (dec.size),
        .rd0_num     (op0_reg),
        .rd1_num     (op1_reg),
        .rd0_data    (op0_value),
        .rd1_data    (op1_value),
        .arch_esp    (arch_esp)
    );

    stack_tracker #(.DATA_W(DATA_W)) u_stack_tracker (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .accept        (accept),
        .stack_op      (dec.stack_op),
        .size          (dec.size),
        .wb_reg        (wb_reg),
        .arch_esp      (arch_esp),
        .stack_address (stack_address)
    );

endmodule

/* source/stack_tracker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Speculative stack pointer
// Generates flat push and pop addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module stack_tracker
    import reg_access_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    input  logic      accept,
    input  stack_op_t stack_op,
    input  op_size_e  size,
    input  gpr_wb_t   wb_reg,
    input  data_t     arch_esp,
    output data_t     stack_address
);

    logic [DATA_W-1:0] spec_esp_q;
    logic [DATA_W-1:0] spec_esp_next;
    logic              is_push;
    logic              esp_wb;

    // Pop has priority when both bits are set
    assign is_push = stack_op[0] && !stack_op[1];

    assign spec_esp_next = spec_esp_q + stack_delta(stack_op, size);

    // Push goes to the decremented ESP, everything else to the current one
    assign stack_address = is_push ? spec_esp_next : spec_esp_q;

    assign esp_wb = wb_reg.en && (wb_reg.number == REG_ESP) && !wb_reg.from_stack;

    // No stack op is in flight when a plain ESP write lands.
    // It also wins over flush, since arch ESP takes the same value at this edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            spec_esp_q <= '0;
        end else if (esp_wb) begin
            spec_esp_q <= wb_reg.data;
        end else if (flush) begin
            spec_esp_q <= arch_esp;
        end else if (accept && (|stack_op)) begin
            spec_esp_q <= spec_esp_next;
        end
    end

endmodule

/* regfile/gpr_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// General register file
// Sized writeback, string stepping, ESP commit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module gpr_file
    import reg_access_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic          clk,
    input  logic          arst_n,

    input  gpr_wb_t       wb_reg,
    input  stack_commit_t wb_stack,

    input  logic          string_step,
    input  logic          flag_df,
    input  op_size_e      step_size,

    input  reg_num_t      rd0_num,
    input  reg_num_t      rd1_num,
    output data_t         rd0_data,
    output data_t         rd1_data,
    output data_t         arch_esp
);

    localparam reg_num_t REG_ESI = 3'd6;
    localparam reg_num_t REG_EDI = 3'd7;

    logic [DATA_W-1:0] gpr_q [8];
    logic [DATA_W-1:0] gpr_d [8];
    logic              step_en;

    // Replace the low byte, low word or the whole register
    function automatic logic [DATA_W-1:0] merge_sized(
        input logic [DATA_W-1:0] old_val,
        input data_t             new_val,
        input op_size_e          size
    );
        logic [DATA_W-1:0] result;
        result = old_val;
        case (size)
            SIZE_BYTE:  result[7:0]  = new_val[7:0];
            SIZE_WORD:  result[15:0] = new_val[15:0];
            SIZE_DWORD: result       = new_val;
            default:    result       = old_val;
        endcase
        return result;
    endfunction

    assign step_en = string_step && (step_size != SIZE_NONE);

    // Later assignments take priority over the writeback
    always_comb begin
        gpr_d = gpr_q;

        if (wb_reg.en) begin
            gpr_d[wb_reg.number] = merge_sized(gpr_q[wb_reg.number], wb_reg.data,
                                               wb_reg.size);
        end

        // MOVS moves both string pointers together
        if (step_en) begin
            gpr_d[REG_ESI] = gpr_q[REG_ESI] + string_delta(step_size, flag_df);
            gpr_d[REG_EDI] = gpr_q[REG_EDI] + string_delta(step_size, flag_df);
        end

        // Architectural ESP only moves on stack commit
        if (wb_stack.en) begin
            gpr_d[REG_ESP] = gpr_q[REG_ESP] + stack_delta(wb_stack.op, wb_stack.size);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpr_q <= '{default: '0};
        end else begin
            gpr_q <= gpr_d;
        end
    end

    // No bypass, a write shows up the cycle after
    assign rd0_data = gpr_q[rd0_num];
    assign rd1_data = gpr_q[rd1_num];
    assign arch_esp = gpr_q[REG_ESP];

endmodule

/* source/esp_write_counter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// In-flight ESP write counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module esp_write_counter
    import reg_access_pkg::*;
#(
    parameter int CNT_W = 3
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    flush,
    input  logic    accept,
    input  logic    esp_dest,
    input  gpr_wb_t wb_reg,
    output logic    stack_stall
);

    logic [CNT_W-1:0] count_q;
    logic             inc;
    logic             dec;

    assign inc = accept && esp_dest;
    assign dec = wb_reg.en && (wb_reg.number == REG_ESP) && !wb_reg.from_stack;

    // Saturates at both ends
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (flush) begin
            count_q <= '0;
        end else if (inc && !dec && (count_q != '1)) begin
            count_q <= count_q + 1'b1;
        end else if (dec && !inc && (count_q != '0)) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign stack_stall = |count_q;

endmodule

/* source/stage_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage handshake controller
// Owns the issue output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module stage_ctrl
    import reg_access_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          flush,

    input  logic          d_valid,
    output logic          d_ready,
    output logic          r_valid,
    input  logic          r_ready,

    input  logic          is_stack_op,
    input  logic          stack_stall,

    input  issue_bundle_t next_issue,
    output issue_bundle_t issue,
    output logic          accept
);

    typedef enum logic {
        EMPTY = 1'b0,
        FULL  = 1'b1
    } state_e;

    state_e        state_q;
    state_e        state_d;
    issue_bundle_t issue_q;
    logic          drain;
    logic          live_q;

    assign r_valid = (state_q == FULL);
    assign drain   = r_valid && r_ready;

    // Room when empty or draining this edge; stack ops wait on ESP writes
    assign d_ready = live_q
                     && ((state_q == EMPTY) || r_ready)
                     && (!stack_stall || !is_stack_op)
                     && !flush;

    assign accept = d_valid && d_ready;

    always_comb begin
        state_d = state_q;
        if (flush) begin
            state_d = EMPTY;
        end else if (accept) begin
            state_d = FULL;
        end else if (drain) begin
            state_d = EMPTY;
        end
    end

    // Ready stays low until the first edge out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= EMPTY;
            live_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            live_q  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue_q <= next_issue;
        end
    end

    assign issue = issue_q;

endmodule

/* common/reg_access_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register access stage shared types
// Widths, encodings, bundles and step rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package reg_access_pkg;

    typedef logic [31:0] data_t;
    typedef logic [2:0]  reg_num_t;

    // Bit 1 pop, bit 0 push
    typedef logic [1:0]  stack_op_t;

    typedef enum logic [1:0] {
        SIZE_NONE  = 2'd0,
        SIZE_BYTE  = 2'd1,
        SIZE_WORD  = 2'd2,
        SIZE_DWORD = 2'd3
    } op_size_e;

    typedef enum logic [2:0] {
        OPK_NONE      = 3'd0,
        OPK_REG       = 3'd1,
        OPK_IMM       = 3'd2,
        OPK_MEM       = 3'd3,
        OPK_MODRM_REG = 3'd4
    } operand_kind_e;

    localparam reg_num_t REG_ESP = 3'd4;

    typedef struct packed {
        op_size_e      size;
        operand_kind_e op0_kind;
        operand_kind_e op1_kind;
        reg_num_t      op0_reg;
        reg_num_t      op1_reg;
        logic [7:0]    modrm;
        stack_op_t     stack_op;
        logic          movs;
        logic [3:0]    alu_op;
        data_t         imm;
        data_t         pc;
    } decode_bundle_t;

    typedef struct packed {
        op_size_e      size;
        operand_kind_e op0_kind;
        operand_kind_e op1_kind;
        reg_num_t      op0_reg;
        reg_num_t      op1_reg;
        stack_op_t     stack_op;
        logic          movs;
        logic [3:0]    alu_op;
        data_t         imm;
        data_t         pc;
        data_t         op0_value;
        data_t         op1_value;
        data_t         stack_address;
    } issue_bundle_t;

    typedef struct packed {
        logic     en;
        reg_num_t number;
        op_size_e size;
        logic     from_stack;
        data_t    data;
    } gpr_wb_t;

    typedef struct packed {
        logic      en;
        op_size_e  size;
        stack_op_t op;
    } stack_commit_t;

    // ESP offset of one stack operation, pop wins if both bits are set
    function automatic data_t stack_delta(input stack_op_t op, input op_size_e size);
        data_t delta;
        delta = '0;
        if (op[1]) begin
            delta = (size == SIZE_DWORD) ? 32'd4 : 32'd2;
        end else if (op[0]) begin
            case (size)
                SIZE_DWORD: delta = 32'hFFFF_FFFC;
                SIZE_WORD:  delta = 32'hFFFF_FFFE;
                default:    delta = 32'hFFFF_FFFF;
            endcase
        end
        return delta;
    endfunction

    // ESI/EDI offset for one string move
    function automatic data_t string_delta(input op_size_e size, input logic df);
        data_t mag;
        case (size)
            SIZE_BYTE:  mag = 32'd1;
            SIZE_WORD:  mag = 32'd2;
            SIZE_DWORD: mag = 32'd4;
            default:    mag = 32'd0;
        endcase
        return df ? (~mag + 32'd1) : mag;
    endfunction

endpackage
